// ==== source/oflow_geom_pkg.sv ====
package oflow_geom_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int COORD_W  = 8; // x, y, w, h of a box
	localparam int COLOR_W  = 8; // color code
	localparam int CENTER_W = 9; // coord plus half size needs one more bit
	localparam int WEIGHT_W = 4; // one score weight

	// raw box as it arrives, 40 bits
	typedef struct packed {
		logic [COORD_W-1:0] x; // left edge
		logic [COORD_W-1:0] y; // top edge
		logic [COORD_W-1:0] w;
		logic [COORD_W-1:0] h;
		logic [COLOR_W-1:0] color;
	} bbox_t;

	// feature vector kept per box, 42 bits
	typedef struct packed {
		logic [CENTER_W-1:0] cx; // x + w/2, rounded down
		logic [CENTER_W-1:0] cy; // y + h/2, rounded down
		logic [COORD_W-1:0]  w;
		logic [COORD_W-1:0]  h;
		logic [COLOR_W-1:0]  color;
	} feature_t;

endpackage

// ==== source/oflow_track_pkg.sv ====
package oflow_track_pkg;

	// ------------------------------
	// frame and track sizes
	// ------------------------------
	localparam int MAX_BBOXES = 8;  // boxes per frame, upper bound
	localparam int IDX_W      = 3;  // index into one bank
	localparam int CNT_W      = 4;  // box count 0..8
	localparam int ID_W       = 8;  // track id, wraps modulo 256
	localparam int SCORE_W    = 18; // weighted distance

	// first id handed out after reset
	localparam logic [ID_W-1:0] FIRST_ID = 8'd1;

	typedef logic [ID_W-1:0]    track_id_t;
	typedef logic [SCORE_W-1:0] score_t;

endpackage

// ==== source/oflow_match_if.sv ====
`timescale 1ns/1ps

// link between history buffer and registration
interface oflow_match_if;

	// driven by registration
	logic [oflow_track_pkg::IDX_W-1:0] cur_rd_idx;  // current box being scored
	logic [oflow_track_pkg::IDX_W-1:0] prev_rd_idx; // previous box under test
	logic                              id_wr_en;    // id write into current bank
	logic [oflow_track_pkg::IDX_W-1:0] id_wr_idx;
	oflow_track_pkg::track_id_t        id_wr_data;
	logic                              swap;        // one cycle at frame end

	// driven by buffer, one cycle after the index
	oflow_geom_pkg::feature_t   cur_feature;
	oflow_geom_pkg::feature_t   prev_feature;
	oflow_track_pkg::track_id_t prev_id;

	modport buffer (
		input  cur_rd_idx, prev_rd_idx, id_wr_en, id_wr_idx, id_wr_data, swap,
		output cur_feature, prev_feature, prev_id
	);

	modport registration (
		output cur_rd_idx, prev_rd_idx, id_wr_en, id_wr_idx, id_wr_data, swap,
		input  cur_feature, prev_feature, prev_id
	);

endinterface

// ==== source/oflow_feature_extract.sv ====
`timescale 1ns/1ps

module oflow_feature_extract (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              new_frame_i,
	input  logic [oflow_track_pkg::CNT_W-1:0] num_bbox_i,     // 1..8
	input  logic                              bbox_valid_i,
	input  oflow_geom_pkg::bbox_t             bbox_i,
	input  logic                              done_frame_i,   // registration finished
	output logic                              ready_new_frame_o,
	output logic                              feat_wr_en_o,
	output logic [oflow_track_pkg::IDX_W-1:0] feat_wr_idx_o,
	output oflow_geom_pkg::feature_t          feat_wr_data_o,
	output logic                              frame_end_o,    // all boxes written
	output logic [oflow_track_pkg::CNT_W-1:0] frame_count_o
);

	logic                              frame_open; // boxes of a frame accepted
	logic [oflow_track_pkg::CNT_W-1:0] exp_cnt;    // boxes announced
	logic [oflow_track_pkg::CNT_W-1:0] arr_cnt;    // boxes arrived so far
	logic                              take_frame;
	logic                              take_box;
	logic                              last_box;
	oflow_geom_pkg::feature_t          feat;

	assign take_frame    = new_frame_i && ready_new_frame_o;
	assign take_box      = bbox_valid_i && frame_open; // stray strobes dropped
	assign last_box      = (arr_cnt + 1'b1) == exp_cnt;
	assign frame_count_o = exp_cnt; // stable for the whole frame

	// centers from top-left corner plus half size
	always_comb begin
		feat.cx    = {1'b0, bbox_i.x} + {2'b00, bbox_i.w[oflow_geom_pkg::COORD_W-1:1]};
		feat.cy    = {1'b0, bbox_i.y} + {2'b00, bbox_i.h[oflow_geom_pkg::COORD_W-1:1]};
		feat.w     = bbox_i.w;
		feat.h     = bbox_i.h;
		feat.color = bbox_i.color;
	end

	// ------------------------------
	// frame control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ready_new_frame_o <= 1'b1;
			frame_open        <= 1'b0;
			exp_cnt           <= '0;
			arr_cnt           <= '0;
			feat_wr_en_o      <= 1'b0;
			frame_end_o       <= 1'b0;
		end else begin
			feat_wr_en_o <= take_box;
			frame_end_o  <= take_box && last_box; // same cycle as last write
			if (take_frame) begin
				ready_new_frame_o <= 1'b0;
				frame_open        <= 1'b1;
				exp_cnt           <= num_bbox_i;
				arr_cnt           <= '0;
			end
			if (take_box) begin
				arr_cnt <= arr_cnt + 1'b1;
				if (last_box)
					frame_open <= 1'b0; // wait for registration to finish
			end
			if (done_frame_i)
				ready_new_frame_o <= 1'b1;
		end
	end

	// feature write, index in arrival order
	always_ff @(posedge clk) begin
		if (take_box) begin
			feat_wr_idx_o  <= arr_cnt[oflow_track_pkg::IDX_W-1:0];
			feat_wr_data_o <= feat;
		end
	end

endmodule

// ==== source/oflow_bank_mem.sv ====
`timescale 1ns/1ps

module oflow_bank_mem #(
	parameter type payload_t = logic [7:0]
) (
	input  logic                              clk,
	input  logic                              bank_sel_i,    // bank holding the current frame
	input  logic                              wr_en_i,
	input  logic [oflow_track_pkg::IDX_W-1:0] wr_idx_i,
	input  payload_t                          wr_data_i,
	input  logic [oflow_track_pkg::IDX_W-1:0] cur_rd_idx_i,
	output payload_t                          cur_rd_data_o,
	input  logic [oflow_track_pkg::IDX_W-1:0] prev_rd_idx_i,
	output payload_t                          prev_rd_data_o
);

	payload_t bank0 [oflow_track_pkg::MAX_BBOXES];
	payload_t bank1 [oflow_track_pkg::MAX_BBOXES];

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			if (bank_sel_i)
				bank1[wr_idx_i] <= wr_data_i;
			else
				bank0[wr_idx_i] <= wr_data_i;
		end
		cur_rd_data_o  <= bank_sel_i ? bank1[cur_rd_idx_i] : bank0[cur_rd_idx_i];
		prev_rd_data_o <= bank_sel_i ? bank0[prev_rd_idx_i] : bank1[prev_rd_idx_i]; // other bank
	end

endmodule

// ==== source/oflow_history_buffer.sv ====
`timescale 1ns/1ps

module oflow_history_buffer (
	input  logic                              clk,
	input  logic                              reset_i,
	input  logic                              feat_wr_en_i,   // from feature extraction
	input  logic [oflow_track_pkg::IDX_W-1:0] feat_wr_idx_i,
	input  oflow_geom_pkg::feature_t          feat_wr_data_i,
	oflow_match_if.buffer                     match
);

	logic bank_sel; // 0: bank0 is current, bank1 holds previous frame

	// current and previous trade places once the frame is registered
	always_ff @(posedge clk) begin
		if (reset_i)
			bank_sel <= 1'b0;
		else if (match.swap)
			bank_sel <= ~bank_sel;
	end

	// ------------------------------
	// feature banks
	// ------------------------------
	oflow_bank_mem #(
		.payload_t (oflow_geom_pkg::feature_t)
	) oflow_feature_mem (
		.clk            (clk),
		.bank_sel_i     (bank_sel),
		.wr_en_i        (feat_wr_en_i),
		.wr_idx_i       (feat_wr_idx_i),
		.wr_data_i      (feat_wr_data_i),
		.cur_rd_idx_i   (match.cur_rd_idx),
		.cur_rd_data_o  (match.cur_feature),
		.prev_rd_idx_i  (match.prev_rd_idx),
		.prev_rd_data_o (match.prev_feature)
	);

	// ------------------------------
	// id banks
	// ------------------------------
	oflow_bank_mem #(
		.payload_t (oflow_track_pkg::track_id_t)
	) oflow_id_mem (
		.clk            (clk),
		.bank_sel_i     (bank_sel),
		.wr_en_i        (match.id_wr_en), // ids of current frame
		.wr_idx_i       (match.id_wr_idx),
		.wr_data_i      (match.id_wr_data),
		.cur_rd_idx_i   (match.cur_rd_idx),
		.cur_rd_data_o  (),                // current ids are never read back
		.prev_rd_idx_i  (match.prev_rd_idx),
		.prev_rd_data_o (match.prev_id)
	);

endmodule

// ==== source/oflow_registration.sv ====
`timescale 1ns/1ps

module oflow_registration (
	input  logic                                 clk,
	input  logic                                 reset_i,
	input  logic                                 frame_end_i,   // current bank complete
	input  logic [oflow_track_pkg::CNT_W-1:0]    frame_count_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0]  pos_weight_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0]  size_weight_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0]  color_weight_i,
	input  oflow_track_pkg::score_t              match_th_i,
	oflow_match_if.registration                  match,
	output logic                                 id_valid_o,
	output logic [oflow_track_pkg::IDX_W-1:0]    id_idx_o,
	output oflow_track_pkg::track_id_t           id_o,
	output logic                                 done_frame_o
);

	typedef enum logic [2:0] {S_IDLE, S_SCAN, S_WAIT, S_FRESH, S_DONE} state_t;

	localparam int PAD_W = oflow_track_pkg::SCORE_W - oflow_geom_pkg::CENTER_W;
	localparam int WPAD_W = oflow_track_pkg::SCORE_W - oflow_geom_pkg::WEIGHT_W;

	state_t                            state;
	logic [oflow_track_pkg::IDX_W-1:0] cur_idx, prev_idx;
	logic [oflow_track_pkg::CNT_W-1:0] cur_count, prev_count;
	oflow_track_pkg::track_id_t        next_id;   // fresh id counter
	logic rd_v_q, rd_first_q, rd_last_q;          // read stage
	logic sc_v, sc_first, sc_last;                // score stage
	logic min_done;                               // minimum final for this box
	oflow_track_pkg::score_t    score_now, sc_score, min_score;
	oflow_track_pkg::track_id_t sc_id, min_id;
	logic prev_last, cur_last, assign_now, assign_hit, done_q;

	function automatic oflow_track_pkg::score_t abs_diff(
		input logic [oflow_geom_pkg::CENTER_W-1:0] a,
		input logic [oflow_geom_pkg::CENTER_W-1:0] b
	);
		logic [oflow_geom_pkg::CENTER_W-1:0] d;
		d = (a > b) ? a - b : b - a;
		return {{PAD_W{1'b0}}, d};
	endfunction

	// weighted L1 distance on the read-stage pair
	always_comb begin
		score_now = {{WPAD_W{1'b0}}, pos_weight_i}
			* (abs_diff(match.cur_feature.cx, match.prev_feature.cx)
			+ abs_diff(match.cur_feature.cy, match.prev_feature.cy))
			+ {{WPAD_W{1'b0}}, size_weight_i}
			* (abs_diff({1'b0, match.cur_feature.w}, {1'b0, match.prev_feature.w})
			+ abs_diff({1'b0, match.cur_feature.h}, {1'b0, match.prev_feature.h}))
			+ {{WPAD_W{1'b0}}, color_weight_i}
			* abs_diff({1'b0, match.cur_feature.color}, {1'b0, match.prev_feature.color});
	end

	assign prev_last  = ({1'b0, prev_idx} + 1'b1) == prev_count;
	assign cur_last   = ({1'b0, cur_idx} + 1'b1) == cur_count;
	assign assign_now = (state == S_WAIT && min_done) || state == S_FRESH;
	assign assign_hit = (state == S_WAIT) && (min_score <= match_th_i); // empty history never hits

	assign match.cur_rd_idx  = cur_idx;
	assign match.prev_rd_idx = prev_idx;
	assign match.id_wr_en    = id_valid_o; // emitted id also lands in current bank
	assign match.id_wr_idx   = id_idx_o;
	assign match.id_wr_data  = id_o;
	assign match.swap        = done_q;
	assign done_frame_o      = done_q;

	// ------------------------------
	// control and pipeline valids
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state      <= S_IDLE;
			cur_idx    <= '0;
			prev_idx   <= '0;
			cur_count  <= '0;
			prev_count <= '0; // no history after reset
			next_id    <= oflow_track_pkg::FIRST_ID;
			rd_v_q     <= 1'b0;
			rd_first_q <= 1'b0;
			rd_last_q  <= 1'b0;
			sc_v       <= 1'b0;
			sc_first   <= 1'b0;
			sc_last    <= 1'b0;
			min_done   <= 1'b0;
			id_valid_o <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			rd_v_q     <= state == S_SCAN;
			rd_first_q <= state == S_SCAN && prev_idx == '0;
			rd_last_q  <= state == S_SCAN && prev_last;
			sc_v       <= rd_v_q;
			sc_first   <= rd_first_q;
			sc_last    <= rd_last_q;
			min_done   <= sc_v && sc_last;
			id_valid_o <= assign_now;
			done_q     <= state == S_DONE; // one cycle after the last id
			if (assign_now && !assign_hit)
				next_id <= next_id + 1'b1; // wraps modulo 256
			case (state)
				S_IDLE: if (frame_end_i) begin
					cur_count <= frame_count_i;
					cur_idx   <= '0;
					prev_idx  <= '0;
					state     <= (prev_count == '0) ? S_FRESH : S_SCAN;
				end
				S_SCAN: begin
					prev_idx <= prev_idx + 1'b1; // one previous box per cycle
					if (prev_last)
						state <= S_WAIT;
				end
				S_WAIT, S_FRESH: if (assign_now) begin
					if (cur_last) begin
						state <= S_DONE;
					end else begin
						cur_idx  <= cur_idx + 1'b1;
						prev_idx <= '0;
						state    <= (state == S_WAIT) ? S_SCAN : S_FRESH;
					end
				end
				S_DONE: begin
					prev_count <= cur_count; // this frame becomes history
					state      <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// score, minimum and id payload
	always_ff @(posedge clk) begin
		if (rd_v_q) begin
			sc_score <= score_now;
			sc_id    <= match.prev_id;
		end
		if (sc_v && (sc_first || sc_score < min_score)) begin // strict, lowest index wins ties
			min_score <= sc_score;
			min_id    <= sc_id;
		end
		if (assign_now) begin
			id_idx_o <= cur_idx;
			id_o     <= assign_hit ? min_id : next_id;
		end
	end

endmodule

// ==== source/oflow_core.sv ====
`timescale 1ns/1ps

module oflow_core (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic                                new_frame_i,
	input  logic [oflow_track_pkg::CNT_W-1:0]   num_bbox_i,
	input  logic                                bbox_valid_i,
	input  oflow_geom_pkg::bbox_t               bbox_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0] pos_weight_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0] size_weight_i,
	input  logic [oflow_geom_pkg::WEIGHT_W-1:0] color_weight_i,
	input  oflow_track_pkg::score_t             match_th_i,
	output logic                                ready_new_frame_o,
	output logic                                id_valid_o,
	output logic [oflow_track_pkg::IDX_W-1:0]   id_idx_o,
	output oflow_track_pkg::track_id_t          id_o,
	output logic                                done_frame_o
);

	// ------------------------------
	// producer to buffer and registration
	// ------------------------------
	logic                              feat_wr_en;
	logic [oflow_track_pkg::IDX_W-1:0] feat_wr_idx;
	oflow_geom_pkg::feature_t          feat_wr_data;
	logic                              frame_end;
	logic [oflow_track_pkg::CNT_W-1:0] frame_count;

	oflow_match_if match (); // buffer <-> registration

	oflow_feature_extract oflow_feature_extract (
		.clk               (clk),
		.reset_i           (reset_i),
		.new_frame_i       (new_frame_i),
		.num_bbox_i        (num_bbox_i),
		.bbox_valid_i      (bbox_valid_i),
		.bbox_i            (bbox_i),
		.done_frame_i      (done_frame_o), // reopens for next frame
		.ready_new_frame_o (ready_new_frame_o),
		.feat_wr_en_o      (feat_wr_en),
		.feat_wr_idx_o     (feat_wr_idx),
		.feat_wr_data_o    (feat_wr_data),
		.frame_end_o       (frame_end),
		.frame_count_o     (frame_count)
	);

	oflow_history_buffer oflow_history_buffer (
		.clk            (clk),
		.reset_i        (reset_i),
		.feat_wr_en_i   (feat_wr_en),
		.feat_wr_idx_i  (feat_wr_idx),
		.feat_wr_data_i (feat_wr_data),
		.match          (match.buffer)
	);

	oflow_registration oflow_registration (
		.clk            (clk),
		.reset_i        (reset_i),
		.frame_end_i    (frame_end),
		.frame_count_i  (frame_count),
		.pos_weight_i   (pos_weight_i),
		.size_weight_i  (size_weight_i),
		.color_weight_i (color_weight_i),
		.match_th_i     (match_th_i),
		.match          (match.registration),
		.id_valid_o     (id_valid_o),
		.id_idx_o       (id_idx_o),
		.id_o           (id_o),
		.done_frame_o   (done_frame_o)
	);

endmodule

// ==== tests/oflow_core_tb.sv ====
`timescale 1ns/1ps

module oflow_core_tb;

	localparam int CYCLE_LIMIT = 20 * 150; // 20 frames, 150 cycles each

	logic                                clk;
	logic                                reset_i;
	logic                                new_frame_i;
	logic [oflow_track_pkg::CNT_W-1:0]   num_bbox_i;
	logic                                bbox_valid_i;
	oflow_geom_pkg::bbox_t               bbox_i;
	logic [oflow_geom_pkg::WEIGHT_W-1:0] pos_weight_i;
	logic [oflow_geom_pkg::WEIGHT_W-1:0] size_weight_i;
	logic [oflow_geom_pkg::WEIGHT_W-1:0] color_weight_i;
	oflow_track_pkg::score_t             match_th_i;
	logic                                ready_new_frame_o;
	logic                                id_valid_o;
	logic [oflow_track_pkg::IDX_W-1:0]   id_idx_o;
	oflow_track_pkg::track_id_t          id_o;
	logic                                done_frame_o;

	int cycles = 0;
	int seed   = 32'hc31;

	// frame under test and what came back
	oflow_geom_pkg::bbox_t      frame_boxes [oflow_track_pkg::MAX_BBOXES];
	int                         frame_n;
	oflow_track_pkg::track_id_t got_ids [oflow_track_pkg::MAX_BBOXES];

	// reference model state, previous frame only
	oflow_geom_pkg::feature_t   prev_feat [oflow_track_pkg::MAX_BBOXES];
	oflow_track_pkg::track_id_t prev_ids [oflow_track_pkg::MAX_BBOXES];
	int                         prev_n = 0;
	oflow_track_pkg::track_id_t next_fresh = 8'd1;

	oflow_geom_pkg::bbox_t base [5]; // five boxes well apart
	int                    perm [5] = '{3, 0, 4, 1, 2};

	oflow_core UUT (.*);

	always #20 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			fail_run($sformatf("timeout after %0d cycles, a frame never finished", cycles));
	end

	// ------------------------------
	// helpers and compare tasks
	// ------------------------------
	task automatic fail_run(string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic step(); // drive point, 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic check_id(string name, oflow_track_pkg::track_id_t got,
			oflow_track_pkg::track_id_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_idx(string name, logic [oflow_track_pkg::IDX_W-1:0] got,
			logic [oflow_track_pkg::IDX_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic oflow_geom_pkg::bbox_t make_box(int x, int y, int w, int h, int c);
		oflow_geom_pkg::bbox_t b;
		b.x     = x[7:0];
		b.y     = y[7:0];
		b.w     = w[7:0];
		b.h     = h[7:0];
		b.color = c[7:0];
		return b;
	endfunction

	// center is corner plus half size, rounded down
	function automatic oflow_geom_pkg::feature_t to_feature(oflow_geom_pkg::bbox_t b);
		oflow_geom_pkg::feature_t f;
		int cx;
		int cy;
		cx      = int'(b.x) + int'(b.w) / 2;
		cy      = int'(b.y) + int'(b.h) / 2;
		f.cx    = cx[8:0];
		f.cy    = cy[8:0];
		f.w     = b.w;
		f.h     = b.h;
		f.color = b.color;
		return f;
	endfunction

	function automatic int absd(int a, int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic int pair_score(oflow_geom_pkg::feature_t a, oflow_geom_pkg::feature_t b);
		return int'(pos_weight_i) * (absd(int'(a.cx), int'(b.cx)) + absd(int'(a.cy), int'(b.cy)))
			+ int'(size_weight_i) * (absd(int'(a.w), int'(b.w)) + absd(int'(a.h), int'(b.h)))
			+ int'(color_weight_i) * absd(int'(a.color), int'(b.color));
	endfunction

	// ------------------------------
	// one frame through DUT and model
	// ------------------------------
	task automatic run_frame();
		oflow_geom_pkg::feature_t   cur_feat [oflow_track_pkg::MAX_BBOXES];
		oflow_track_pkg::track_id_t exp_ids [oflow_track_pkg::MAX_BBOXES];
		oflow_track_pkg::track_id_t best_id;
		int best;
		int score;
		int pulses;
		for (int i = 0; i < frame_n; i++) begin
			cur_feat[i] = to_feature(frame_boxes[i]);
			best        = -1;
			best_id     = '0;
			for (int j = 0; j < prev_n; j++) begin
				score = pair_score(cur_feat[i], prev_feat[j]);
				if (best < 0 || score < best) begin // first lowest index kept on ties
					best    = score;
					best_id = prev_ids[j];
				end
			end
			if (best >= 0 && best <= int'(match_th_i)) begin
				exp_ids[i] = best_id;
			end else begin
				exp_ids[i] = next_fresh;
				next_fresh = next_fresh + 8'd1; // wraps like the id counter
			end
		end
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1);
		new_frame_i = 1'b1;
		num_bbox_i  = frame_n[oflow_track_pkg::CNT_W-1:0];
		step();
		new_frame_i = 1'b0;
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b0);
		for (int i = 0; i < frame_n; i++) begin
			bbox_valid_i = 1'b1;
			bbox_i       = frame_boxes[i];
			step();
		end
		bbox_valid_i = 1'b0;
		pulses       = 0;
		while (!done_frame_o) begin
			if (id_valid_o && pulses >= frame_n) begin
				fail_run("more id pulses than boxes in the frame");
			end else begin
				if (id_valid_o) begin
					check_idx("id_idx_o", id_idx_o, pulses[oflow_track_pkg::IDX_W-1:0]);
					check_id("id_o", id_o, exp_ids[pulses]);
					got_ids[pulses] = id_o;
					pulses++;
				end
				check_bit("ready_new_frame_o", ready_new_frame_o, 1'b0);
				step();
			end
		end
		check_bit("id_valid_o", id_valid_o, 1'b0);
		if (pulses != frame_n)
			fail_run($sformatf("frame ended after %0d ids, %0d boxes sent", pulses, frame_n));
		step();
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1); // reopens after done
		check_bit("done_frame_o", done_frame_o, 1'b0);
		for (int i = 0; i < frame_n; i++) begin
			prev_feat[i] = cur_feat[i];
			prev_ids[i]  = exp_ids[i];
		end
		prev_n = frame_n;
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic first_frame_after_reset();
		check_bit("ready_new_frame_o", ready_new_frame_o, 1'b1);
		check_bit("id_valid_o", id_valid_o, 1'b0);
		check_bit("done_frame_o", done_frame_o, 1'b0);
		for (int i = 0; i < 5; i++)
			frame_boxes[i] = base[i];
		frame_n = 5;
		run_frame();
		for (int i = 0; i < 5; i++)
			check_id("id_o", got_ids[i], oflow_track_pkg::track_id_t'(i + 1));
	endtask

	task automatic reordered_frame();
		for (int i = 0; i < 5; i++)
			frame_boxes[i] = base[perm[i]];
		run_frame();
		for (int i = 0; i < 5; i++)
			check_id("id_o", got_ids[i], oflow_track_pkg::track_id_t'(perm[i] + 1));
	endtask

	task automatic moved_boxes();
		for (int i = 0; i < 4; i++)
			frame_boxes[i].x = frame_boxes[i].x + 8'd2; // score 4, under threshold
		frame_boxes[4] = make_box(230, 10, 20, 20, 3); // far away
		run_frame();
		for (int i = 0; i < 4; i++)
			check_id("id_o", got_ids[i], oflow_track_pkg::track_id_t'(perm[i] + 1));
		check_id("id_o", got_ids[4], 8'd6);
	endtask

	task automatic color_weighting();
		oflow_track_pkg::track_id_t kept [5];
		for (int i = 0; i < 5; i++) begin
			kept[i]              = prev_ids[i];
			frame_boxes[i].color = frame_boxes[i].color + 8'd50;
		end
		color_weight_i = 4'd0; // color ignored
		run_frame();
		for (int i = 0; i < 5; i++)
			check_id("id_o", got_ids[i], kept[i]);
		for (int i = 0; i < 5; i++)
			frame_boxes[i].color = frame_boxes[i].color + 8'd10;
		color_weight_i = 4'd15; // 150 per box now
		run_frame();
		for (int i = 0; i < 5; i++)
			check_id("id_o", got_ids[i], oflow_track_pkg::track_id_t'(7 + i));
	endtask

	task automatic tie_and_shared_track();
		oflow_track_pkg::track_id_t tie_id;
		frame_boxes[0] = make_box(200, 200, 10, 10, 7);
		frame_boxes[1] = make_box(200, 200, 10, 10, 7); // same box, second fresh id
		frame_boxes[2] = make_box(20, 150, 10, 10, 9);
		frame_n        = 3;
		run_frame();
		tie_id  = prev_ids[0];
		frame_n = 2;
		run_frame(); // both copies claim the lower index
		check_id("id_o", got_ids[0], tie_id);
		check_id("id_o", got_ids[1], tie_id);
		color_weight_i = 4'd1;
	endtask

	task automatic random_frames();
		oflow_geom_pkg::bbox_t rnd [oflow_track_pkg::MAX_BBOXES];
		int n;
		n = ($unsigned($random(seed)) % 8) + 1;
		for (int i = 0; i < n; i++) begin
			rnd[i] = make_box($random(seed) & 255, $random(seed) & 255, $random(seed) & 255,
				$random(seed) & 255, $random(seed) & 255);
			frame_boxes[i] = rnd[i];
		end
		frame_n = n;
		run_frame();
		for (int i = 0; i < 8; i++) begin // full frame, jittered copies
			frame_boxes[i]   = rnd[i % n];
			frame_boxes[i].x = frame_boxes[i].x + 8'd1;
		end
		frame_n = 8;
		run_frame();
		for (int i = 0; i < 8; i++)
			rnd[i] = frame_boxes[i];
		for (int i = 0; i < 8; i++) begin
			frame_boxes[i]   = rnd[7 - i];
			frame_boxes[i].y = frame_boxes[i].y + 8'd1;
		end
		run_frame();
	endtask

	initial begin
		clk            = 1'b0;
		reset_i        = 1'b1;
		new_frame_i    = 1'b0;
		num_bbox_i     = '0;
		bbox_valid_i   = 1'b0;
		bbox_i         = '0;
		pos_weight_i   = 4'd2;
		size_weight_i  = 4'd1;
		color_weight_i = 4'd1;
		match_th_i     = 18'd20;
		base[0]        = make_box(10, 10, 20, 20, 1);
		base[1]        = make_box(60, 10, 20, 20, 2);
		base[2]        = make_box(110, 10, 20, 20, 3);
		base[3]        = make_box(10, 80, 20, 20, 4);
		base[4]        = make_box(60, 80, 20, 20, 5);
		repeat (10) step();
		reset_i = 1'b0;
		first_frame_after_reset();
		reordered_frame();
		moved_boxes();
		color_weighting();
		tie_and_shared_track();
		random_frames();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== src.f ====
source/oflow_geom_pkg.sv
source/oflow_track_pkg.sv
source/oflow_match_if.sv
source/oflow_feature_extract.sv
source/oflow_bank_mem.sv
source/oflow_history_buffer.sv
source/oflow_registration.sv
source/oflow_core.sv
tests/oflow_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the oflow_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=oflow_core_tb

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -f src.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished with status 0"
exit 0
